// ==== Bender.yml ====
package:
  name: cpu

sources:
  - verilog/cpuPkg.sv
  - verilog/fetch.sv
  - verilog/decode.sv
  - verilog/forwardUnit.sv
  - verilog/execute.sv
  - verilog/hazardDetection.sv
  - verilog/memory.sv
  - verilog/cpu.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/cpuTb.sv

// ==== cpu.f ====
+incdir+tb
verilog/cpuPkg.sv
verilog/fetch.sv
verilog/decode.sv
verilog/forwardUnit.sv
verilog/execute.sv
verilog/hazardDetection.sv
verilog/memory.sv
verilog/cpu.sv
tb/cpuTb.sv

// ==== tb/cpuTbModel.svh ====
// RV32I encoders, field order as in the ISA manual
function automatic logic [31:0] rType(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
	return {f7, rs2, rs1, f3, rd, cpuPkg::OPC_OP};
endfunction

function automatic logic [31:0] iType(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input cpuPkg::rvOpcodeE opc);
	return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] sType(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1);
	return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], cpuPkg::OPC_STORE};
endfunction

// Byte offset, bit 0 dropped by the format
function automatic logic [31:0] bType(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
	return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], cpuPkg::OPC_BRANCH};
endfunction

function automatic logic [31:0] jType(input logic [20:0] imm, input logic [4:0] rd);
	return {imm[20], imm[10:1], imm[11], imm[19:12], rd, cpuPkg::OPC_JAL};
endfunction

function automatic logic [31:0] uType(input logic [19:0] imm, input logic [4:0] rd);
	return {imm, rd, cpuPkg::OPC_LUI};
endfunction

function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic sub,
		input logic [31:0] x, input logic [31:0] y);
	case (f3)
		3'b000: return sub ? x - y : x + y;
		3'b001: return x << y[4:0];
		3'b010: return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
		3'b100: return x ^ y;
		3'b101: return x >> y[4:0];
		3'b110: return x | y;
		default: return x & y;
	endcase
endfunction

// In-order ISA model of prog, fills the expected I/O stores
function automatic int runModel(input logic [31:0] joy);
	logic [31:0] regs [32];
	logic [31:0] ram [1024];
	logic [31:0] pc;
	logic [31:0] ins;
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] immI;
	logic [31:0] immS;
	logic [31:0] immB;
	logic [31:0] immJ;
	logic [31:0] addr;
	logic [31:0] res;
	logic [31:0] nextPc;
	logic wr;
	logic done;
	int retired;
	foreach (regs[i]) begin
		regs[i] = '0;
	end
	foreach (ram[i]) begin
		ram[i] = '0;
	end
	expAddr.delete();
	expData.delete();
	pc = '0;
	done = 1'b0;
	retired = 0;
	while (!done && retired < STEP_LIMIT) begin
		ins = prog[pc[9:2]];
		a = regs[ins[19:15]];
		b = regs[ins[24:20]];
		immI = {{20{ins[31]}}, ins[31:20]};
		immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
		immB = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
		immJ = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
		nextPc = pc + 32'd4;
		wr = 1'b0;
		res = '0;
		retired++;
		case (ins[6:0])
			7'b0110011: begin
				wr = 1'b1;
				res = aluRef(ins[14:12], ins[30], a, b);
			end
			7'b0010011: begin
				wr = 1'b1;
				res = aluRef(ins[14:12], 1'b0, a, immI);
			end
			7'b0110111: begin
				wr = 1'b1;
				res = {ins[31:12], 12'b0};
			end
			7'b0000011: begin
				wr = 1'b1;
				addr = a + immI;
				res = (|addr[31:15]) ? joy : ram[addr[11:2]];
			end
			7'b0100011: begin
				addr = a + immS;
				if (|addr[31:15]) begin
					expAddr.push_back(addr);
					expData.push_back(b);
				end else begin
					ram[addr[11:2]] = b;
				end
			end
			7'b1100011: begin
				if ((a == b) != ins[12]) begin
					nextPc = pc + immB;
				end
			end
			7'b1101111: begin
				wr = 1'b1;
				res = pc + 32'd4;
				nextPc = pc + immJ;
			end
			// ECALL, or anything unknown, ends the program
			default: done = 1'b1;
		endcase
		if (wr && ins[11:7] != 5'd0) begin
			regs[ins[11:7]] = res;
		end
		pc = nextPc;
	end
	return retired;
endfunction

// ==== tb/cpuTb.sv ====
`timescale 1ns/1ps

module cpuTb;

	localparam int PROG_WORDS = 256;
	localparam int RESET_CYCLES = 5;
	localparam int DRAIN_CYCLES = 10;
	localparam int STEP_LIMIT = 10000;

	logic clk;
	logic rst;
	logic debug;
	logic [cpuPkg::XLEN-1:0] bootAddr;
	logic [cpuPkg::XLEN-1:0] bootData;
	logic [cpuPkg::XLEN-1:0] joystickData;
	logic [cpuPkg::XLEN-1:0] memMappedAddr;
	logic [cpuPkg::XLEN-1:0] memMappedDataOut;
	logic memMappedWrite;
	logic halt;

	logic [31:0] prog [PROG_WORDS];
	int progLen;
	logic [31:0] expAddr [$];
	logic [31:0] expData [$];
	logic monitorOn;
	integer seed;
	int wordErrors;
	int flagErrors;
	int otherErrors;

	`include "cpuTbModel.svh"

	cpu cpu_i(
		.clk(clk),
		.rst(rst),
		.bootAddr(bootAddr),
		.bootData(bootData),
		.debug(debug),
		.memMappedAddr(memMappedAddr),
		.memMappedDataOut(memMappedDataOut),
		.memMappedWrite(memMappedWrite),
		.joystickData(joystickData),
		.halt(halt)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic nextCycle();
		@(posedge clk);
		#2;
	endtask

	task automatic checkWord(input string what, input logic [cpuPkg::XLEN-1:0] got,
			input logic [cpuPkg::XLEN-1:0] exp);
		if (got !== exp) begin
			wordErrors++;
			$display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic checkFlag(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			flagErrors++;
			$display("ERROR at %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	// Each I/O store is matched in order against the model
	always @(negedge clk) begin
		if (monitorOn && memMappedWrite !== 1'b0) begin
			if (halt === 1'b1) begin
				otherErrors++;
				$display("I/O store to %h seen after halt", memMappedAddr);
			end else if (expAddr.size() == 0) begin
				otherErrors++;
				$display("Unexpected I/O store to %h", memMappedAddr);
			end else begin
				checkWord("I/O store address", memMappedAddr, expAddr.pop_front());
				checkWord("I/O store data", memMappedDataOut, expData.pop_front());
			end
		end
	end

	task automatic emit(input logic [31:0] word);
		prog[progLen] = word;
		progLen++;
	endtask

	// LUI plus ADDI, upper part rounded for the sign of the low 12 bits
	task automatic loadConst(input logic [4:0] rd, input logic [31:0] value);
		logic [31:0] upper;
		upper = (value + 32'h800) >> 12;
		emit(uType(upper[19:0], rd));
		emit(iType(value[11:0], rd, 3'b000, rd, cpuPkg::OPC_OP_IMM));
	endtask

	task automatic storeWord(input logic [4:0] rs2, input logic [4:0] base,
			input logic [11:0] off);
		emit(sType(off, rs2, base));
	endtask

	task automatic loadWord(input logic [4:0] rd, input logic [4:0] base,
			input logic [11:0] off);
		emit(iType(off, base, 3'b010, rd, cpuPkg::OPC_LOAD));
	endtask

	task automatic buildAluProgram();
		logic [31:0] r;
		int i;
		progLen = 0;
		emit(uType(20'h10, 5'd31));
		r = $random(seed);
		loadConst(5'd1, r);
		r = $random(seed);
		loadConst(5'd2, r);
		// Every instruction depends on the one before it
		emit(rType(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
		emit(rType(7'h20, 5'd1, 5'd3, 3'b000, 5'd4));
		emit(rType(7'h00, 5'd2, 5'd4, 3'b111, 5'd5));
		emit(rType(7'h00, 5'd3, 5'd5, 3'b110, 5'd6));
		emit(rType(7'h00, 5'd4, 5'd6, 3'b100, 5'd7));
		emit(rType(7'h00, 5'd1, 5'd7, 3'b010, 5'd8));
		emit(rType(7'h00, 5'd2, 5'd7, 3'b001, 5'd9));
		emit(rType(7'h00, 5'd1, 5'd9, 3'b101, 5'd10));
		r = $random(seed);
		emit(iType(r[11:0], 5'd10, 3'b000, 5'd11, cpuPkg::OPC_OP_IMM));
		emit(iType(r[23:12], 5'd11, 3'b100, 5'd12, cpuPkg::OPC_OP_IMM));
		r = $random(seed);
		emit(iType(r[11:0], 5'd12, 3'b110, 5'd13, cpuPkg::OPC_OP_IMM));
		emit(iType(r[23:12], 5'd13, 3'b111, 5'd14, cpuPkg::OPC_OP_IMM));
		emit(iType(r[31:20], 5'd7, 3'b010, 5'd15, cpuPkg::OPC_OP_IMM));
		emit(iType({7'b0, r[4:0]}, 5'd14, 3'b001, 5'd16, cpuPkg::OPC_OP_IMM));
		emit(iType({7'b0, r[9:5]}, 5'd16, 3'b101, 5'd17, cpuPkg::OPC_OP_IMM));
		emit(uType(r[31:12], 5'd18));
		for (i = 18; i >= 3; i--) begin
			storeWord(i[4:0], 5'd31, 12'(4 * i));
		end
		emit({25'b0, cpuPkg::OPC_SYSTEM});
	endtask

	task automatic buildLoadProgram();
		logic [31:0] r;
		progLen = 0;
		emit(uType(20'h10, 5'd31));
		emit(iType(12'h100, 5'd0, 3'b000, 5'd20, cpuPkg::OPC_OP_IMM));
		r = $random(seed);
		loadConst(5'd1, r);
		r = $random(seed);
		loadConst(5'd2, r);
		storeWord(5'd1, 5'd20, 12'd0);
		storeWord(5'd2, 5'd20, 12'd4);
		loadWord(5'd3, 5'd20, 12'd0);
		emit(rType(7'h00, 5'd2, 5'd3, 3'b000, 5'd4));
		storeWord(5'd4, 5'd31, 12'd0);
		// Loaded register as store data right away
		loadWord(5'd5, 5'd20, 12'd4);
		storeWord(5'd5, 5'd31, 12'd4);
		loadWord(5'd6, 5'd20, 12'd0);
		storeWord(5'd6, 5'd20, 12'd8);
		loadWord(5'd7, 5'd20, 12'd8);
		emit(iType(12'd1, 5'd7, 3'b000, 5'd8, cpuPkg::OPC_OP_IMM));
		storeWord(5'd8, 5'd31, 12'd8);
		// Loaded register as store base
		storeWord(5'd31, 5'd20, 12'd12);
		loadWord(5'd12, 5'd20, 12'd12);
		storeWord(5'd1, 5'd12, 12'd16);
		loadWord(5'd9, 5'd20, 12'd4);
		emit(rType(7'h20, 5'd9, 5'd1, 3'b000, 5'd10));
		storeWord(5'd10, 5'd31, 12'd20);
		emit({25'b0, cpuPkg::OPC_SYSTEM});
	endtask

	task automatic buildBranchProgram();
		logic [31:0] r;
		progLen = 0;
		emit(uType(20'h10, 5'd31));
		r = $random(seed);
		loadConst(5'd1, r);
		emit(iType(12'd0, 5'd1, 3'b000, 5'd2, cpuPkg::OPC_OP_IMM));
		emit(iType(12'd1, 5'd1, 3'b100, 5'd3, cpuPkg::OPC_OP_IMM));
		emit(bType(13'd8, 5'd2, 5'd1, 3'b000));
		storeWord(5'd1, 5'd31, 12'd100);
		storeWord(5'd2, 5'd31, 12'd4);
		emit(bType(13'd8, 5'd2, 5'd1, 3'b001));
		storeWord(5'd3, 5'd31, 12'd8);
		storeWord(5'd1, 5'd31, 12'd12);
		emit(bType(13'd12, 5'd3, 5'd1, 3'b001));
		storeWord(5'd1, 5'd31, 12'd104);
		storeWord(5'd2, 5'd31, 12'd108);
		storeWord(5'd3, 5'd31, 12'd16);
		emit(bType(13'd8, 5'd3, 5'd1, 3'b000));
		storeWord(5'd2, 5'd31, 12'd20);
		emit(jType(21'd12, 5'd5));
		storeWord(5'd1, 5'd31, 12'd112);
		storeWord(5'd1, 5'd31, 12'd116);
		storeWord(5'd5, 5'd31, 12'd24);
		// Five passes, counter tested right after its decrement
		emit(iType(12'd0, 5'd0, 3'b000, 5'd6, cpuPkg::OPC_OP_IMM));
		emit(iType(12'd5, 5'd0, 3'b000, 5'd7, cpuPkg::OPC_OP_IMM));
		emit(iType(12'd3, 5'd6, 3'b000, 5'd6, cpuPkg::OPC_OP_IMM));
		storeWord(5'd6, 5'd31, 12'd28);
		emit(iType(12'hfff, 5'd7, 3'b000, 5'd7, cpuPkg::OPC_OP_IMM));
		emit(bType(-13'sd12, 5'd0, 5'd7, 3'b001));
		emit({25'b0, cpuPkg::OPC_SYSTEM});
	endtask

	task automatic buildIoLoadProgram();
		progLen = 0;
		emit(uType(20'h10, 5'd31));
		loadWord(5'd1, 5'd31, 12'd0);
		storeWord(5'd1, 5'd31, 12'd0);
		loadWord(5'd2, 5'd31, 12'd64);
		emit(rType(7'h00, 5'd1, 5'd2, 3'b000, 5'd3));
		storeWord(5'd3, 5'd31, 12'd4);
		emit(uType(20'h80000, 5'd21));
		loadWord(5'd4, 5'd21, 12'd0);
		storeWord(5'd4, 5'd31, 12'd8);
		emit({25'b0, cpuPkg::OPC_SYSTEM});
	endtask

	task automatic buildHaltProgram();
		logic [31:0] r;
		progLen = 0;
		emit(uType(20'h10, 5'd31));
		r = $random(seed);
		loadConst(5'd1, r);
		storeWord(5'd1, 5'd31, 12'd0);
		emit({25'b0, cpuPkg::OPC_SYSTEM});
		storeWord(5'd1, 5'd31, 12'd4);
		storeWord(5'd1, 5'd31, 12'd8);
		emit(iType(12'd1, 5'd1, 3'b000, 5'd1, cpuPkg::OPC_OP_IMM));
		storeWord(5'd1, 5'd31, 12'd12);
	endtask

	task automatic resetCpu();
		int i;
		monitorOn = 1'b0;
		rst = 1'b1;
		debug = 1'b0;
		for (i = 0; i < RESET_CYCLES; i++) begin
			nextCycle();
		end
		rst = 1'b0;
	endtask

	task automatic runProgram(input string name);
		logic [31:0] joy;
		int retired;
		int limit;
		int cycles;
		int i;
		joy = $random(seed);
		retired = runModel(joy);
		limit = progLen + 3 * retired + 40;
		resetCpu();
		joystickData = joy;
		checkFlag("halt after reset", halt, 1'b0);
		checkFlag("memMappedWrite after reset", memMappedWrite, 1'b0);
		monitorOn = 1'b1;
		cycles = 0;
		debug = 1'b1;
		for (i = 0; i < progLen; i++) begin
			bootAddr = i;
			bootData = prog[i];
			nextCycle();
			cycles++;
		end
		debug = 1'b0;
		while (halt !== 1'b1) begin
			if (cycles >= limit) begin
				$display("Timeout: program %s did not halt within %0d cycles", name, limit);
				$display("Test FAILED");
				$finish;
			end
			nextCycle();
			cycles++;
		end
		// Halt must hold with the pipeline quiet
		for (i = 0; i < DRAIN_CYCLES; i++) begin
			nextCycle();
			checkFlag("halt", halt, 1'b1);
		end
		monitorOn = 1'b0;
		if (expAddr.size() != 0) begin
			otherErrors++;
			$display("Program %s: %0d expected I/O stores never appeared", name, expAddr.size());
		end
		$display("Program %s: %0d instructions, halted after %0d cycles", name, retired, cycles);
	endtask

	initial begin
		rst = 1'b1;
		debug = 1'b0;
		bootAddr = '0;
		bootData = '0;
		joystickData = '0;
		monitorOn = 1'b0;
		progLen = 0;
		seed = 32'hde001fc9;
		wordErrors = 0;
		flagErrors = 0;
		otherErrors = 0;
		buildAluProgram();
		runProgram("alu");
		buildLoadProgram();
		runProgram("load-use");
		buildBranchProgram();
		runProgram("branch");
		buildIoLoadProgram();
		runProgram("joystick");
		buildHaltProgram();
		runProgram("ecall");
		// Fresh operands, booted after a reset out of the halted state
		buildAluProgram();
		runProgram("second boot");
		$display("Errors: %0d word, %0d flag, %0d other", wordErrors, flagErrors, otherErrors);
		if (wordErrors + flagErrors + otherErrors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

// ==== verilog/cpu.sv ====
`timescale 1ns/1ps

module cpu(
	input wire clk,
	input wire rst,

	input wire [cpuPkg::XLEN-1:0] bootAddr,
	input wire [cpuPkg::XLEN-1:0] bootData,
	input wire debug,

	output logic [cpuPkg::XLEN-1:0] memMappedAddr,
	output logic [cpuPkg::XLEN-1:0] memMappedDataOut,
	output logic memMappedWrite,
	input wire [cpuPkg::XLEN-1:0] joystickData,

	output logic halt
);

	// Pipeline registers
	cpuPkg::ifIdS ifId;
	cpuPkg::idExS idEx;
	cpuPkg::exMemS exMem;
	cpuPkg::memWbS memWb;

	// Decode to hazard unit
	logic [4:0] idRs1;
	logic [4:0] idRs2;

	// Forwarded EX operands
	logic [cpuPkg::XLEN-1:0] operandA;
	logic [cpuPkg::XLEN-1:0] operandB;

	// Control flow
	logic redirect;
	logic [cpuPkg::XLEN-1:0] redirectPc;
	logic stall;
	logic flushIfId;
	logic flushIdEx;

	// Writeback
	logic wbEnable;
	logic [4:0] wbRd;
	logic [cpuPkg::XLEN-1:0] wbData;

	logic haltReg;
	logic squash;

	fetch iFetch(
		.clk(clk),
		.rst(rst),
		.debug(debug),
		.bootAddr(bootAddr),
		.bootData(bootData),
		.stall(stall),
		.flushIfId(flushIfId),
		.redirect(redirect),
		.redirectPc(redirectPc),
		.halt(squash),
		.ifId(ifId)
	);

	decode iDecode(
		.clk(clk),
		.rst(rst),
		.ifId(ifId),
		.stall(stall),
		.flushIdEx(flushIdEx),
		.wbEnable(wbEnable),
		.wbRd(wbRd),
		.wbData(wbData),
		.idEx(idEx),
		.idRs1(idRs1),
		.idRs2(idRs2)
	);

	forwardUnit iForward(
		.idEx(idEx),
		.exMem(exMem),
		.wbEnable(wbEnable),
		.wbRd(wbRd),
		.wbData(wbData),
		.operandA(operandA),
		.operandB(operandB)
	);

	execute iExecute(
		.clk(clk),
		.rst(rst),
		.idEx(idEx),
		.operandA(operandA),
		.operandB(operandB),
		.halt(squash),
		.exMem(exMem),
		.redirect(redirect),
		.redirectPc(redirectPc)
	);

	hazardDetection iHazardDetect(
		.idEx(idEx),
		.idRs1(idRs1),
		.idRs2(idRs2),
		.redirect(redirect),
		.stall(stall),
		.flushIfId(flushIfId),
		.flushIdEx(flushIdEx)
	);

	memory iMemory(
		.clk(clk),
		.rst(rst),
		.exMem(exMem),
		.joystickData(joystickData),
		.memWb(memWb),
		.memMappedAddr(memMappedAddr),
		.memMappedDataOut(memMappedDataOut),
		.memMappedWrite(memMappedWrite)
	);

	// Writeback mux
	assign wbData = memWb.memRead ? memWb.loadData : memWb.result;
	assign wbEnable = memWb.regWrite;
	assign wbRd = memWb.rd;

	// Sticky until reset
	always_ff @(posedge clk) begin
		if (rst) begin
			haltReg <= 1'b0;
		end else if (memWb.isEcall) begin
			haltReg <= 1'b1;
		end
	end

	assign halt = haltReg || memWb.isEcall;

	// Squash starts once ECALL leaves EX, so nothing younger reaches MEM
	assign squash = halt || exMem.isEcall;

endmodule

// ==== verilog/cpuPkg.sv ====
package cpuPkg;

	// Datapath and memory sizes
	localparam int XLEN = 32;
	localparam int IMEM_WORDS = 1024;
	localparam int DMEM_WORDS = 1024;
	localparam int IMEM_AW = $clog2(IMEM_WORDS);
	localparam int DMEM_AW = $clog2(DMEM_WORDS);

	// Any address bit from here up to 31 selects I/O
	localparam int MMIO_LOW_BIT = 15;

	// addi x0, x0, 0
	localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013;

	typedef enum logic [6:0] {
		OPC_OP     = 7'b0110011,
		OPC_OP_IMM = 7'b0010011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_BRANCH = 7'b1100011,
		OPC_JAL    = 7'b1101111,
		OPC_LUI    = 7'b0110111,
		OPC_SYSTEM = 7'b1110011
	} rvOpcodeE;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLL,
		ALU_SRL,
		ALU_PASSB
	} aluOpE;

	typedef struct packed {
		logic [XLEN-1:0] pc;
		logic [XLEN-1:0] instr;
		logic valid;
	} ifIdS;

	typedef struct packed {
		logic [XLEN-1:0] pc;
		logic [XLEN-1:0] rs1Data;
		logic [XLEN-1:0] rs2Data;
		logic [XLEN-1:0] imm;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [4:0] rd;
		aluOpE aluOp;
		logic useImm;
		logic memRead;
		logic memWrite;
		logic regWrite;
		logic isBranch;
		logic branchNe;
		logic isJal;
		logic isEcall;
		logic valid;
	} idExS;

	typedef struct packed {
		logic [XLEN-1:0] result;
		logic [XLEN-1:0] storeData;
		logic [4:0] rd;
		logic memRead;
		logic memWrite;
		logic regWrite;
		logic isEcall;
	} exMemS;

	typedef struct packed {
		logic [XLEN-1:0] result;
		logic [XLEN-1:0] loadData;
		logic [4:0] rd;
		logic memRead;
		logic regWrite;
		logic isEcall;
	} memWbS;

endpackage

// ==== verilog/decode.sv ====
`timescale 1ns/1ps

module decode(
	input wire clk,
	input wire rst,
	input cpuPkg::ifIdS ifId,
	input wire stall,
	input wire flushIdEx,
	input wire wbEnable,
	input wire [4:0] wbRd,
	input wire [cpuPkg::XLEN-1:0] wbData,
	output cpuPkg::idExS idEx,
	output logic [4:0] idRs1,
	output logic [4:0] idRs2
);

	logic [cpuPkg::XLEN-1:0] regs [32];
	logic [cpuPkg::XLEN-1:0] instr;
	cpuPkg::rvOpcodeE opcode;
	logic [2:0] funct3;
	logic [4:0] rd;
	logic [cpuPkg::XLEN-1:0] imm;
	cpuPkg::aluOpE funct3Op;
	cpuPkg::idExS dec;

	assign instr = ifId.instr;
	assign opcode = cpuPkg::rvOpcodeE'(instr[6:0]);
	assign funct3 = instr[14:12];
	assign rd = instr[11:7];
	assign idRs1 = instr[19:15];
	assign idRs2 = instr[24:20];

	// x0 is never written and reads as zero below
	always_ff @(posedge clk) begin
		if (wbEnable && wbRd != 5'd0) begin
			regs[wbRd] <= wbData;
		end
	end

	// Same-cycle writeback passes straight through
	function automatic logic [cpuPkg::XLEN-1:0] readReg(input logic [4:0] idx);
		if (idx == 5'd0) begin
			return '0;
		end
		if (wbEnable && wbRd == idx) begin
			return wbData;
		end
		return regs[idx];
	endfunction

	always_comb begin
		case (opcode)
			cpuPkg::OPC_STORE: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
			cpuPkg::OPC_BRANCH:
				imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
			cpuPkg::OPC_JAL:
				imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
			cpuPkg::OPC_LUI: imm = {instr[31:12], 12'b0};
			default: imm = {{20{instr[31]}}, instr[31:20]};
		endcase
	end

	// Shared by register and immediate ALU forms
	always_comb begin
		case (funct3)
			3'b001: funct3Op = cpuPkg::ALU_SLL;
			3'b010: funct3Op = cpuPkg::ALU_SLT;
			3'b100: funct3Op = cpuPkg::ALU_XOR;
			3'b101: funct3Op = cpuPkg::ALU_SRL;
			3'b110: funct3Op = cpuPkg::ALU_OR;
			3'b111: funct3Op = cpuPkg::ALU_AND;
			default: funct3Op = cpuPkg::ALU_ADD;
		endcase
	end

	always_comb begin
		dec = '0;
		dec.pc = ifId.pc;
		dec.rs1Data = readReg(idRs1);
		dec.rs2Data = readReg(idRs2);
		dec.imm = imm;
		dec.rs1 = idRs1;
		dec.rs2 = idRs2;
		dec.rd = rd;
		dec.aluOp = cpuPkg::ALU_ADD;
		dec.valid = ifId.valid;
		if (ifId.valid) begin
			case (opcode)
				cpuPkg::OPC_OP: begin
					dec.regWrite = 1'b1;
					if (funct3 == 3'b000 && instr[30]) begin
						dec.aluOp = cpuPkg::ALU_SUB;
					end else begin
						dec.aluOp = funct3Op;
					end
				end
				cpuPkg::OPC_OP_IMM: begin
					dec.regWrite = 1'b1;
					dec.useImm = 1'b1;
					dec.aluOp = funct3Op;
				end
				cpuPkg::OPC_LOAD: begin
					dec.regWrite = 1'b1;
					dec.useImm = 1'b1;
					dec.memRead = 1'b1;
				end
				cpuPkg::OPC_STORE: begin
					dec.useImm = 1'b1;
					dec.memWrite = 1'b1;
				end
				cpuPkg::OPC_BRANCH: begin
					dec.isBranch = 1'b1;
					dec.branchNe = funct3[0];
				end
				cpuPkg::OPC_JAL: begin
					dec.regWrite = 1'b1;
					dec.isJal = 1'b1;
				end
				cpuPkg::OPC_LUI: begin
					dec.regWrite = 1'b1;
					dec.useImm = 1'b1;
					dec.aluOp = cpuPkg::ALU_PASSB;
				end
				cpuPkg::OPC_SYSTEM: dec.isEcall = 1'b1;
				default: dec.valid = 1'b0;
			endcase
		end
	end

	// ID/EX register, bubble on stall or flush
	always_ff @(posedge clk) begin
		if (rst || stall || flushIdEx) begin
			idEx <= '0;
		end else begin
			idEx <= dec;
		end
	end

endmodule

// ==== verilog/execute.sv ====
`timescale 1ns/1ps

module execute(
	input wire clk,
	input wire rst,
	input cpuPkg::idExS idEx,
	input wire [cpuPkg::XLEN-1:0] operandA,
	input wire [cpuPkg::XLEN-1:0] operandB,
	input wire halt,
	output cpuPkg::exMemS exMem,
	output logic redirect,
	output logic [cpuPkg::XLEN-1:0] redirectPc
);

	logic [cpuPkg::XLEN-1:0] srcB;
	logic [cpuPkg::XLEN-1:0] aluResult;
	logic [cpuPkg::XLEN-1:0] linkPc;
	logic taken;

	assign srcB = idEx.useImm ? idEx.imm : operandB;
	assign linkPc = idEx.pc + 32'd4;

	always_comb begin
		case (idEx.aluOp)
			cpuPkg::ALU_SUB: aluResult = operandA - srcB;
			cpuPkg::ALU_AND: aluResult = operandA & srcB;
			cpuPkg::ALU_OR: aluResult = operandA | srcB;
			cpuPkg::ALU_XOR: aluResult = operandA ^ srcB;
			cpuPkg::ALU_SLT: aluResult = {31'b0, $signed(operandA) < $signed(srcB)};
			cpuPkg::ALU_SLL: aluResult = operandA << srcB[4:0];
			cpuPkg::ALU_SRL: aluResult = operandA >> srcB[4:0];
			cpuPkg::ALU_PASSB: aluResult = srcB;
			default: aluResult = operandA + srcB;
		endcase
	end

	// BEQ/BNE share one compare, funct3 bit 0 inverts it
	assign taken = idEx.isBranch && ((operandA == operandB) != idEx.branchNe);
	assign redirect = idEx.valid && (taken || idEx.isJal) && !halt;
	assign redirectPc = idEx.pc + idEx.imm;

	// EX/MEM register
	always_ff @(posedge clk) begin
		exMem.result <= idEx.isJal ? linkPc : aluResult;
		exMem.storeData <= operandB;
		exMem.rd <= idEx.rd;
		if (rst || halt) begin
			exMem.memRead <= 1'b0;
			exMem.memWrite <= 1'b0;
			exMem.regWrite <= 1'b0;
			exMem.isEcall <= 1'b0;
		end else begin
			exMem.memRead <= idEx.memRead;
			exMem.memWrite <= idEx.memWrite;
			exMem.regWrite <= idEx.regWrite;
			exMem.isEcall <= idEx.isEcall;
		end
	end

endmodule

// ==== verilog/fetch.sv ====
`timescale 1ns/1ps

module fetch(
	input wire clk,
	input wire rst,
	input wire debug,
	input wire [cpuPkg::XLEN-1:0] bootAddr,
	input wire [cpuPkg::XLEN-1:0] bootData,
	input wire stall,
	input wire flushIfId,
	input wire redirect,
	input wire [cpuPkg::XLEN-1:0] redirectPc,
	input wire halt,
	output cpuPkg::ifIdS ifId
);

	logic [cpuPkg::XLEN-1:0] imem [cpuPkg::IMEM_WORDS];
	logic [cpuPkg::XLEN-1:0] pc;
	logic [cpuPkg::XLEN-1:0] instr;

	// Boot loader writes one word per cycle, bootAddr is a word index
	always_ff @(posedge clk) begin
		if (debug) begin
			imem[bootAddr[cpuPkg::IMEM_AW-1:0]] <= bootData;
		end
	end

	assign instr = imem[pc[cpuPkg::IMEM_AW+1:2]];

	// PC sits at 0 while booting
	always_ff @(posedge clk) begin
		if (rst || debug) begin
			pc <= '0;
		end else if (redirect) begin
			pc <= redirectPc;
		end else if (!stall && !halt) begin
			pc <= pc + 32'd4;
		end
	end

	// IF/ID register
	always_ff @(posedge clk) begin
		if (rst || debug || flushIfId || halt) begin
			ifId.pc <= '0;
			ifId.instr <= cpuPkg::NOP_INSTR;
			ifId.valid <= 1'b0;
		end else if (!stall) begin
			ifId.pc <= pc;
			ifId.instr <= instr;
			ifId.valid <= 1'b1;
		end
	end

endmodule

// ==== verilog/forwardUnit.sv ====
`timescale 1ns/1ps

module forwardUnit(
	input cpuPkg::idExS idEx,
	input cpuPkg::exMemS exMem,
	input wire wbEnable,
	input wire [4:0] wbRd,
	input wire [cpuPkg::XLEN-1:0] wbData,
	output logic [cpuPkg::XLEN-1:0] operandA,
	output logic [cpuPkg::XLEN-1:0] operandB
);

	logic exMemFwdOk;

	// A load in EX/MEM has no data yet, the hazard unit stalls for it
	assign exMemFwdOk = exMem.regWrite && !exMem.memRead && exMem.rd != 5'd0;

	// Youngest producer wins
	function automatic logic [cpuPkg::XLEN-1:0] pick(
		input logic [4:0] rs,
		input logic [cpuPkg::XLEN-1:0] regVal
	);
		if (exMemFwdOk && exMem.rd == rs) begin
			return exMem.result;
		end
		if (wbEnable && wbRd != 5'd0 && wbRd == rs) begin
			return wbData;
		end
		return regVal;
	endfunction

	always_comb begin
		operandA = pick(idEx.rs1, idEx.rs1Data);
		operandB = pick(idEx.rs2, idEx.rs2Data);
	end

endmodule

// ==== verilog/hazardDetection.sv ====
`timescale 1ns/1ps

module hazardDetection(
	input cpuPkg::idExS idEx,
	input wire [4:0] idRs1,
	input wire [4:0] idRs2,
	input wire redirect,
	output logic stall,
	output logic flushIfId,
	output logic flushIdEx
);

	logic loadUse;

	// Load in EX feeding the instruction in decode
	assign loadUse = idEx.memRead && idEx.rd != 5'd0
		&& (idEx.rd == idRs1 || idEx.rd == idRs2);

	// Redirect squashes the waiting instruction anyway
	assign stall = loadUse && !redirect;

	// Two bubbles on redirect
	assign flushIfId = redirect;
	assign flushIdEx = redirect;

endmodule

// ==== verilog/memory.sv ====
`timescale 1ns/1ps

module memory(
	input wire clk,
	input wire rst,
	input cpuPkg::exMemS exMem,
	input wire [cpuPkg::XLEN-1:0] joystickData,
	output cpuPkg::memWbS memWb,
	output logic [cpuPkg::XLEN-1:0] memMappedAddr,
	output logic [cpuPkg::XLEN-1:0] memMappedDataOut,
	output logic memMappedWrite
);

	logic [cpuPkg::XLEN-1:0] dmem [cpuPkg::DMEM_WORDS];
	logic [cpuPkg::DMEM_AW-1:0] wordIdx;
	logic isIo;

	assign isIo = |exMem.result[cpuPkg::XLEN-1:cpuPkg::MMIO_LOW_BIT];
	assign wordIdx = exMem.result[cpuPkg::DMEM_AW+1:2];

	always_ff @(posedge clk) begin
		if (exMem.memWrite && !isIo) begin
			dmem[wordIdx] <= exMem.storeData;
		end
	end

	// I/O store strobe lasts the one MEM cycle
	assign memMappedAddr = exMem.result;
	assign memMappedDataOut = exMem.storeData;
	assign memMappedWrite = exMem.memWrite && isIo;

	// MEM/WB register
	always_ff @(posedge clk) begin
		memWb.result <= exMem.result;
		memWb.loadData <= isIo ? joystickData : dmem[wordIdx];
		memWb.rd <= exMem.rd;
		if (rst) begin
			memWb.memRead <= 1'b0;
			memWb.regWrite <= 1'b0;
			memWb.isEcall <= 1'b0;
		end else begin
			memWb.memRead <= exMem.memRead;
			memWb.regWrite <= exMem.regWrite;
			memWb.isEcall <= exMem.isEcall;
		end
	end

endmodule
